//--- source/ex_pkg.sv
package ex_pkg;

	// general register file address width
	localparam int REG_ADDR_W = 5;

	// forwarded hi/lo words are always one architectural word
	localparam int WORD_W = 32;

	// exception word layout
	localparam int EXC_W        = 32;
	localparam int EXC_OV_BIT   = 11; // arithmetic overflow
	localparam int EXC_TRAP_BIT = 10; // trap, never raised here

	// operation codes, same encoding as the decode stage
	typedef enum logic [7:0] {
		EXE_NOP_OP   = 8'b0000_0000,
		EXE_AND_OP   = 8'b0010_0100,
		EXE_OR_OP    = 8'b0010_0101,
		EXE_XOR_OP   = 8'b0010_0110,
		EXE_NOR_OP   = 8'b0010_0111,
		EXE_SLL_OP   = 8'b0111_1100,
		EXE_SRL_OP   = 8'b0000_0010,
		EXE_SRA_OP   = 8'b0000_0011,
		EXE_MOVZ_OP  = 8'b0000_1010,
		EXE_MOVN_OP  = 8'b0000_1011,
		EXE_MFHI_OP  = 8'b0001_0000,
		EXE_MTHI_OP  = 8'b0001_0001,
		EXE_MFLO_OP  = 8'b0001_0010,
		EXE_MTLO_OP  = 8'b0001_0011,
		EXE_MULT_OP  = 8'b0001_1000,
		EXE_MULTU_OP = 8'b0001_1001,
		EXE_ADD_OP   = 8'b0010_0000,
		EXE_ADDU_OP  = 8'b0010_0001,
		EXE_SUB_OP   = 8'b0010_0010,
		EXE_SUBU_OP  = 8'b0010_0011,
		EXE_SLT_OP   = 8'b0010_1010,
		EXE_SLTU_OP  = 8'b0010_1011,
		EXE_ADDI_OP  = 8'b0101_0101,
		EXE_ADDIU_OP = 8'b0101_0110
	} alu_op_e;

	// result class, picks which unit feeds wdata
	typedef enum logic [2:0] {
		EXE_RES_NOP         = 3'b000,
		EXE_RES_LOGIC       = 3'b001,
		EXE_RES_SHIFT       = 3'b010,
		EXE_RES_MOVE        = 3'b011,
		EXE_RES_ARITH       = 3'b100,
		EXE_RES_JUMP_BRANCH = 3'b110
	} alu_sel_e;

	// hi/lo write as seen in a later pipeline stage
	typedef struct packed {
		logic              we;
		logic [WORD_W-1:0] hi;
		logic [WORD_W-1:0] lo;
	} hilo_wr_t;

endpackage

//--- source/hilo_if.sv
interface hilo_if #(
	parameter int DATA_W = 32
);

	logic              whilo;    // hi/lo write enable
	logic [DATA_W-1:0] hi;       // value for hi
	logic [DATA_W-1:0] lo;       // value for lo
	logic [DATA_W-1:0] move_res; // mfhi/mflo/movz/movn result

	// hi/lo unit side
	modport producer (
		output whilo,
		output hi,
		output lo,
		output move_res
	);

	// writeback combiner side
	modport consumer (
		input whilo,
		input hi,
		input lo,
		input move_res
	);

endinterface

//--- source/ex_alu.sv
module ex_alu #(
	parameter int DATA_W = 32
) (
	input  ex_pkg::alu_op_e    aluop_i,
	input  logic [DATA_W-1:0]  reg1_i,
	input  logic [DATA_W-1:0]  reg2_i,
	output logic [DATA_W-1:0]  alu_res_o,
	output logic               ov_flow_o
);

	localparam int SH_W = $clog2(DATA_W);

	logic [SH_W-1:0]   shamt;
	logic              is_sub;
	logic [DATA_W-1:0] reg2_mux;   // reg2 or its two's complement
	logic [DATA_W-1:0] sum_res;
	logic              reg1_lt_reg2;
	logic              ov_op;
	logic [DATA_W-1:0] logic_res;
	logic [DATA_W-1:0] shift_res;
	logic [DATA_W-1:0] arith_res;

	assign shamt = reg1_i[SH_W-1:0]; // low bits only

	// subtraction and slt go through the adder
	assign is_sub = (aluop_i == ex_pkg::EXE_SUB_OP) ||
			(aluop_i == ex_pkg::EXE_SUBU_OP) ||
			(aluop_i == ex_pkg::EXE_SLT_OP);

	assign reg2_mux = is_sub ? (~reg2_i + 1'b1) : reg2_i;
	assign sum_res  = reg1_i + reg2_mux;

	// signed compare from the difference, unsigned done directly
	always_comb begin
		if (aluop_i == ex_pkg::EXE_SLT_OP) begin
			reg1_lt_reg2 = (reg1_i[DATA_W-1] && !reg2_i[DATA_W-1]) ||
					(!reg1_i[DATA_W-1] && !reg2_i[DATA_W-1] && sum_res[DATA_W-1]) ||
					(reg1_i[DATA_W-1] && reg2_i[DATA_W-1] && sum_res[DATA_W-1]);
		end else begin
			reg1_lt_reg2 = reg1_i < reg2_i;
		end
	end

	// only the trapping forms report overflow
	assign ov_op = (aluop_i == ex_pkg::EXE_ADD_OP) ||
			(aluop_i == ex_pkg::EXE_ADDI_OP) ||
			(aluop_i == ex_pkg::EXE_SUB_OP);

	// same operand signs, result sign flipped
	assign ov_flow_o = ov_op &&
			(reg1_i[DATA_W-1] == reg2_mux[DATA_W-1]) &&
			(sum_res[DATA_W-1] != reg1_i[DATA_W-1]);

	always_comb begin
		case (aluop_i)
			ex_pkg::EXE_AND_OP: logic_res = reg1_i & reg2_i;
			ex_pkg::EXE_OR_OP:  logic_res = reg1_i | reg2_i;
			ex_pkg::EXE_XOR_OP: logic_res = reg1_i ^ reg2_i;
			ex_pkg::EXE_NOR_OP: logic_res = ~(reg1_i | reg2_i);
			default:            logic_res = '0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			ex_pkg::EXE_SLL_OP: shift_res = reg2_i << shamt;
			ex_pkg::EXE_SRL_OP: shift_res = reg2_i >> shamt;
			ex_pkg::EXE_SRA_OP: shift_res = $signed(reg2_i) >>> shamt; // sign fill
			default:            shift_res = '0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			ex_pkg::EXE_ADD_OP,
			ex_pkg::EXE_ADDI_OP,
			ex_pkg::EXE_ADDU_OP,
			ex_pkg::EXE_ADDIU_OP,
			ex_pkg::EXE_SUB_OP,
			ex_pkg::EXE_SUBU_OP: begin
				arith_res = sum_res;
			end
			ex_pkg::EXE_SLT_OP,
			ex_pkg::EXE_SLTU_OP: begin
				arith_res = {{(DATA_W-1){1'b0}}, reg1_lt_reg2};
			end
			default: begin
				arith_res = '0;
			end
		endcase
	end

	// at most one class is non-zero for any op
	assign alu_res_o = logic_res | shift_res | arith_res;

endmodule

//--- source/ex_hilo.sv
module ex_hilo #(
	parameter int DATA_W = 32
) (
	input  ex_pkg::alu_op_e   aluop_i,
	input  logic [DATA_W-1:0] reg1_i,
	input  logic [DATA_W-1:0] reg2_i,
	input  logic [DATA_W-1:0] hi_i,
	input  logic [DATA_W-1:0] lo_i,
	input  ex_pkg::hilo_wr_t  mem_hilo_i,
	input  ex_pkg::hilo_wr_t  wb_hilo_i,
	hilo_if.producer          hilo
);

	logic [DATA_W-1:0]   hi_cur;
	logic [DATA_W-1:0]   lo_cur;
	logic [2*DATA_W-1:0] prod_s;
	logic [2*DATA_W-1:0] prod_u;

	// newest hi/lo, mem stage wins over wb stage
	always_comb begin
		if (mem_hilo_i.we) begin
			hi_cur = mem_hilo_i.hi;
			lo_cur = mem_hilo_i.lo;
		end else if (wb_hilo_i.we) begin
			hi_cur = wb_hilo_i.hi;
			lo_cur = wb_hilo_i.lo;
		end else begin
			hi_cur = hi_i;
			lo_cur = lo_i;
		end
	end

	// kept apart so the signed product stays signed
	assign prod_s = $signed(reg1_i) * $signed(reg2_i);
	assign prod_u = reg1_i * reg2_i;

	// hi/lo write side
	always_comb begin
		hilo.whilo = 1'b0;
		hilo.hi    = '0;
		hilo.lo    = '0;
		case (aluop_i)
			ex_pkg::EXE_MULT_OP: begin
				hilo.whilo = 1'b1;
				hilo.hi    = prod_s[2*DATA_W-1:DATA_W];
				hilo.lo    = prod_s[DATA_W-1:0];
			end
			ex_pkg::EXE_MULTU_OP: begin
				hilo.whilo = 1'b1;
				hilo.hi    = prod_u[2*DATA_W-1:DATA_W];
				hilo.lo    = prod_u[DATA_W-1:0];
			end
			ex_pkg::EXE_MTHI_OP: begin
				// both halves are written, so carry lo along
				hilo.whilo = 1'b1;
				hilo.hi    = reg1_i;
				hilo.lo    = lo_cur;
			end
			ex_pkg::EXE_MTLO_OP: begin
				hilo.whilo = 1'b1;
				hilo.hi    = hi_cur;
				hilo.lo    = reg1_i;
			end
			default: begin
			end
		endcase
	end

	// result for the move class
	always_comb begin
		case (aluop_i)
			ex_pkg::EXE_MFHI_OP: hilo.move_res = hi_cur;
			ex_pkg::EXE_MFLO_OP: hilo.move_res = lo_cur;
			ex_pkg::EXE_MOVZ_OP,
			ex_pkg::EXE_MOVN_OP: hilo.move_res = reg1_i; // condition checked in decode
			default:             hilo.move_res = '0;
		endcase
	end

endmodule

//--- source/ex_writeback.sv
module ex_writeback #(
	parameter int DATA_W = 32
) (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  ex_pkg::alu_sel_e              alusel_i,
	input  logic [DATA_W-1:0]             alu_res_i,
	input  logic                          ov_flow_i,
	hilo_if.consumer                      hilo,
	input  logic [DATA_W-1:0]             link_addr_i,
	input  logic [ex_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                          wreg_i,
	input  logic [ex_pkg::EXC_W-1:0]      except_i,
	output logic [DATA_W-1:0]             wdata_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] wd_o,
	output logic                          wreg_o,
	output logic                          whilo_o,
	output logic [DATA_W-1:0]             hi_o,
	output logic [DATA_W-1:0]             lo_o,
	output logic [ex_pkg::EXC_W-1:0]      except_o
);

	logic [DATA_W-1:0]        wdata_d;
	logic                     wreg_d;
	logic [ex_pkg::EXC_W-1:0] except_d;

	always_comb begin
		case (alusel_i)
			ex_pkg::EXE_RES_LOGIC,
			ex_pkg::EXE_RES_SHIFT,
			ex_pkg::EXE_RES_ARITH:       wdata_d = alu_res_i;
			ex_pkg::EXE_RES_MOVE:        wdata_d = hilo.move_res;
			ex_pkg::EXE_RES_JUMP_BRANCH: wdata_d = link_addr_i; // return address
			default:                     wdata_d = '0;
		endcase
	end

	assign wreg_d = wreg_i && !ov_flow_i; // overflowing add/sub must not write

	always_comb begin
		except_d                       = except_i;
		except_d[ex_pkg::EXC_OV_BIT]   = ov_flow_i;
		except_d[ex_pkg::EXC_TRAP_BIT] = 1'b0;
		except_d[7:0]                  = '0;
	end

	// ex/mem pipeline register
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wdata_o  <= '0;
			wd_o     <= '0;
			wreg_o   <= 1'b0;
			whilo_o  <= 1'b0;
			hi_o     <= '0;
			lo_o     <= '0;
			except_o <= '0;
		end else begin
			wdata_o  <= wdata_d;
			wd_o     <= wd_i;
			wreg_o   <= wreg_d;
			whilo_o  <= hilo.whilo;
			hi_o     <= hilo.hi;
			lo_o     <= hilo.lo;
			except_o <= except_d;
		end
	end

	// an overflow never reaches the register file
	a_ov_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		except_o[ex_pkg::EXC_OV_BIT] |-> !wreg_o);

	a_whilo_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(whilo_o));

	// one cycle latency, checked once reset was high on the previous edge too
	a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
		$past(rst_n_i) |->
		{wdata_o, wd_o, wreg_o, whilo_o, hi_o, lo_o, except_o} ==
		$past({wdata_d, wd_i, wreg_d, hilo.whilo, hilo.hi, hilo.lo, except_d}));

endmodule

//--- source/ex_stage.sv
module ex_stage #(
	parameter int DATA_W = 32
) (
	input  logic                          clk,
	input  logic                          rst_n_i,

	// decoded operation
	input  ex_pkg::alu_op_e               aluop_i,
	input  ex_pkg::alu_sel_e              alusel_i,
	input  logic [DATA_W-1:0]             reg1_i,
	input  logic [DATA_W-1:0]             reg2_i,
	input  logic [ex_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                          wreg_i,
	input  logic [DATA_W-1:0]             link_addr_i,
	input  logic [ex_pkg::EXC_W-1:0]      except_i,

	// hi/lo register file and later stages
	input  logic [DATA_W-1:0]             hi_i,
	input  logic [DATA_W-1:0]             lo_i,
	input  logic                          mem_whilo_i,
	input  logic [DATA_W-1:0]             mem_hi_i,
	input  logic [DATA_W-1:0]             mem_lo_i,
	input  logic                          wb_whilo_i,
	input  logic [DATA_W-1:0]             wb_hi_i,
	input  logic [DATA_W-1:0]             wb_lo_i,

	// to memory stage
	output logic [DATA_W-1:0]             wdata_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] wd_o,
	output logic                          wreg_o,
	output logic                          whilo_o,
	output logic [DATA_W-1:0]             hi_o,
	output logic [DATA_W-1:0]             lo_o,
	output logic [ex_pkg::EXC_W-1:0]      except_o
);

	// forwarding struct holds exactly one word per half
	if (DATA_W != ex_pkg::WORD_W) begin : g_width_check
		$error("ex_stage: DATA_W must equal ex_pkg::WORD_W");
	end

	logic [DATA_W-1:0] alu_res;
	logic              ov_flow;
	ex_pkg::hilo_wr_t  mem_hilo;
	ex_pkg::hilo_wr_t  wb_hilo;

	assign mem_hilo = '{we: mem_whilo_i, hi: mem_hi_i, lo: mem_lo_i};
	assign wb_hilo  = '{we: wb_whilo_i, hi: wb_hi_i, lo: wb_lo_i};

	hilo_if #(.DATA_W(DATA_W)) hilo_bus ();

	ex_alu #(.DATA_W(DATA_W)) u_alu (
		.aluop_i   (aluop_i),
		.reg1_i    (reg1_i),
		.reg2_i    (reg2_i),
		.alu_res_o (alu_res),
		.ov_flow_o (ov_flow)
	);

	ex_hilo #(.DATA_W(DATA_W)) u_hilo (
		.aluop_i    (aluop_i),
		.reg1_i     (reg1_i),
		.reg2_i     (reg2_i),
		.hi_i       (hi_i),
		.lo_i       (lo_i),
		.mem_hilo_i (mem_hilo),
		.wb_hilo_i  (wb_hilo),
		.hilo       (hilo_bus.producer)
	);

	ex_writeback #(.DATA_W(DATA_W)) u_writeback (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.alusel_i    (alusel_i),
		.alu_res_i   (alu_res),
		.ov_flow_i   (ov_flow),
		.hilo        (hilo_bus.consumer),
		.link_addr_i (link_addr_i),
		.wd_i        (wd_i),
		.wreg_i      (wreg_i),
		.except_i    (except_i),
		.wdata_o     (wdata_o),
		.wd_o        (wd_o),
		.wreg_o      (wreg_o),
		.whilo_o     (whilo_o),
		.hi_o        (hi_o),
		.lo_o        (lo_o),
		.except_o    (except_o)
	);

endmodule

//--- verification/ex_stage_tb.sv
module ex_stage_tb;

	localparam int DATA_W       = 32;
	localparam int SH_W         = $clog2(DATA_W);
	localparam int HALF         = 10;
	localparam int EDGE_TIMEOUT = 4 * HALF; // two periods without an edge
	localparam int RESET_CYCLES = 10;
	localparam logic [31:0] LFSR_SEED = 32'h4b7e_1f14;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	logic                          clk;
	logic                          rst_n;
	ex_pkg::alu_op_e               aluop;
	ex_pkg::alu_sel_e              alusel;
	logic [DATA_W-1:0]             reg1;
	logic [DATA_W-1:0]             reg2;
	logic [DATA_W-1:0]             link_addr;
	logic [DATA_W-1:0]             hi;
	logic [DATA_W-1:0]             lo;
	logic [DATA_W-1:0]             mem_hi;
	logic [DATA_W-1:0]             mem_lo;
	logic [DATA_W-1:0]             wb_hi;
	logic [DATA_W-1:0]             wb_lo;
	logic [ex_pkg::REG_ADDR_W-1:0] wd;
	logic                          wreg;
	logic                          mem_whilo;
	logic                          wb_whilo;
	logic [ex_pkg::EXC_W-1:0]      except_in;
	logic [DATA_W-1:0]             wdata_o;
	logic [DATA_W-1:0]             hi_o;
	logic [DATA_W-1:0]             lo_o;
	logic [ex_pkg::REG_ADDR_W-1:0] wd_o;
	logic                          wreg_o;
	logic                          whilo_o;
	logic [ex_pkg::EXC_W-1:0]      except_o;

	logic [31:0]                   lfsr_state;
	logic [ex_pkg::REG_ADDR_W-1:0] cur_wd;   // side inputs of the last issued op
	logic [DATA_W-1:0]             cur_link;
	logic [ex_pkg::EXC_W-1:0]      cur_exc;
	int                            ov_cnt;
	logic [DATA_W-1:0] edge_vals[6] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
			32'hffff_ffff, 32'h8000_0001};

	ex_stage #(.DATA_W(DATA_W)) dut_i (
		.clk(clk), .rst_n_i(rst_n), .aluop_i(aluop), .alusel_i(alusel),
		.reg1_i(reg1), .reg2_i(reg2), .wd_i(wd), .wreg_i(wreg),
		.link_addr_i(link_addr), .except_i(except_in), .hi_i(hi), .lo_i(lo),
		.mem_whilo_i(mem_whilo), .mem_hi_i(mem_hi), .mem_lo_i(mem_lo),
		.wb_whilo_i(wb_whilo), .wb_hi_i(wb_hi), .wb_lo_i(wb_lo),
		.wdata_o(wdata_o), .wd_o(wd_o), .wreg_o(wreg_o), .whilo_o(whilo_o),
		.hi_o(hi_o), .lo_o(lo_o), .except_o(except_o)
	);

	always #(HALF) clk = ~clk;

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val        = {val[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
		end
		return val;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_except(input string name, input logic [ex_pkg::EXC_W-1:0] got,
			input logic [ex_pkg::EXC_W-1:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// waits for n edges of one polarity
	task automatic wait_edges(input logic rising, input int n, input string what);
		logic seen;
		for (int i = 0; i < n; i++) begin
			seen = 1'b0;
			fork
				begin
					if (rising) begin
						@(posedge clk);
					end else begin
						@(negedge clk);
					end
					seen = 1'b1;
				end
				#(EDGE_TIMEOUT);
			join_any
			disable fork;
			if (!seen) stop_run($sformatf("timeout: the clock stopped while %s", what));
		end
	endtask

	// result edge and a mid cycle sample point
	task automatic wait_result();
		wait_edges(1'b1, 1, "waiting for the result edge");
		wait_edges(1'b0, 1, "waiting to sample the result");
	endtask

	task automatic issue(input ex_pkg::alu_op_e op, input ex_pkg::alu_sel_e sel,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic we);
		wait_edges(1'b1, 1, "issuing an operation");
		cur_wd    = rand_bits(ex_pkg::REG_ADDR_W);
		cur_link  = rand_bits(DATA_W);
		cur_exc   = rand_bits(ex_pkg::EXC_W);
		aluop     <= op;
		alusel    <= sel;
		reg1      <= a;
		reg2      <= b;
		wreg      <= we;
		wd        <= cur_wd;
		link_addr <= cur_link;
		except_in <= cur_exc;
	endtask

	task automatic expect_out(input logic [DATA_W-1:0] data,
			input logic [ex_pkg::REG_ADDR_W-1:0] exp_wd, input logic wr, input logic ov,
			input logic hw, input logic [DATA_W-1:0] h, input logic [DATA_W-1:0] l,
			input logic [ex_pkg::EXC_W-1:0] exc_in);
		logic [ex_pkg::EXC_W-1:0] exc;
		exc                       = exc_in;
		exc[ex_pkg::EXC_OV_BIT]   = ov;
		exc[ex_pkg::EXC_TRAP_BIT] = 1'b0;
		exc[7:0]                  = '0; // low byte always cleared
		check_word("wdata_o", wdata_o, data);
		check_word("wd_o", DATA_W'(wd_o), DATA_W'(exp_wd));
		check_flag("wreg_o", wreg_o, wr && !ov); // overflow cancels the write
		check_flag("whilo_o", whilo_o, hw);
		check_word("hi_o", hi_o, h);
		check_word("lo_o", lo_o, l);
		check_except("except_o", except_o, exc);
	endtask

	// results from the instruction definitions
	function automatic logic [DATA_W-1:0] alu_model(input ex_pkg::alu_op_e op,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, output logic ov);
		logic [DATA_W-1:0] neg_b;
		logic [DATA_W-1:0] res;
		neg_b = -b;
		res   = '0;
		ov    = 1'b0;
		case (op)
			ex_pkg::EXE_AND_OP: res = a & b;
			ex_pkg::EXE_OR_OP:  res = a | b;
			ex_pkg::EXE_XOR_OP: res = a ^ b;
			ex_pkg::EXE_NOR_OP: res = ~(a | b);
			ex_pkg::EXE_SLL_OP: res = b << a[SH_W-1:0];
			ex_pkg::EXE_SRL_OP: res = b >> a[SH_W-1:0];
			ex_pkg::EXE_SRA_OP: res = $signed(b) >>> a[SH_W-1:0];
			ex_pkg::EXE_ADD_OP, ex_pkg::EXE_ADDI_OP: begin
				res = a + b;
				ov  = (a[DATA_W-1] == b[DATA_W-1]) && (res[DATA_W-1] != a[DATA_W-1]);
			end
			ex_pkg::EXE_SUB_OP: begin
				res = a + neg_b;
				ov  = (a[DATA_W-1] == neg_b[DATA_W-1]) && (res[DATA_W-1] != a[DATA_W-1]);
			end
			ex_pkg::EXE_ADDU_OP, ex_pkg::EXE_ADDIU_OP: res = a + b;
			ex_pkg::EXE_SUBU_OP: res = a - b;
			ex_pkg::EXE_SLT_OP:  res[0] = $signed(a) < $signed(b);
			ex_pkg::EXE_SLTU_OP: res[0] = a < b;
			default:             res = '0;
		endcase
		return res;
	endfunction

	function automatic ex_pkg::alu_sel_e sel_of(input ex_pkg::alu_op_e op);
		case (op)
			ex_pkg::EXE_AND_OP, ex_pkg::EXE_OR_OP,
			ex_pkg::EXE_XOR_OP, ex_pkg::EXE_NOR_OP: return ex_pkg::EXE_RES_LOGIC;
			ex_pkg::EXE_SLL_OP, ex_pkg::EXE_SRL_OP,
			ex_pkg::EXE_SRA_OP: return ex_pkg::EXE_RES_SHIFT;
			default: return ex_pkg::EXE_RES_ARITH;
		endcase
	endfunction

	task automatic check_alu(input ex_pkg::alu_op_e op, input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] res;
		logic              ov;
		res = alu_model(op, a, b, ov);
		issue(op, sel_of(op), a, b, 1'b1);
		wait_result();
		if (ov) ov_cnt++;
		expect_out(res, cur_wd, 1'b1, ov, 1'b0, '0, '0, cur_exc);
	endtask

	task automatic check_mult(input ex_pkg::alu_op_e op, input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b);
		logic [2*DATA_W-1:0] prod;
		if (op == ex_pkg::EXE_MULT_OP) begin
			prod = $signed({{DATA_W{a[DATA_W-1]}}, a}) * $signed({{DATA_W{b[DATA_W-1]}}, b});
		end else begin
			prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
		end
		issue(op, ex_pkg::EXE_RES_NOP, a, b, 1'b0);
		wait_result();
		expect_out('0, cur_wd, 1'b0, 1'b0, 1'b1, prod[2*DATA_W-1:DATA_W], prod[DATA_W-1:0],
				cur_exc);
	endtask

	// op that would set every output if the register were not held in reset
	task automatic test_reset();
		issue(ex_pkg::EXE_MULT_OP, ex_pkg::EXE_RES_JUMP_BRANCH, rand_bits(DATA_W),
				rand_bits(DATA_W), 1'b1);
		wait_edges(1'b1, RESET_CYCLES - 2, "holding reset");
		wait_edges(1'b0, 1, "sampling during reset");
		expect_out('0, '0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		wait_edges(1'b1, 1, "releasing reset");
		rst_n <= 1'b1;
		wait_edges(1'b0, 1, "sampling after reset release");
		expect_out('0, '0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic test_logic_shift();
		ex_pkg::alu_op_e ops[7] = '{ex_pkg::EXE_AND_OP, ex_pkg::EXE_OR_OP, ex_pkg::EXE_XOR_OP,
				ex_pkg::EXE_NOR_OP, ex_pkg::EXE_SLL_OP, ex_pkg::EXE_SRL_OP, ex_pkg::EXE_SRA_OP};
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		for (int r = 0; r < 5; r++) begin
			a = (r == 0) ? 32'd31 : rand_bits(DATA_W); // full shift first
			b = (r == 0) ? 32'h8000_0001 : rand_bits(DATA_W);
			foreach (ops[k]) check_alu(ops[k], a, b);
		end
	endtask

	task automatic test_arith();
		ex_pkg::alu_op_e ops[8] = '{ex_pkg::EXE_ADD_OP, ex_pkg::EXE_ADDI_OP, ex_pkg::EXE_ADDU_OP,
				ex_pkg::EXE_ADDIU_OP, ex_pkg::EXE_SUB_OP, ex_pkg::EXE_SUBU_OP,
				ex_pkg::EXE_SLT_OP, ex_pkg::EXE_SLTU_OP};
		ov_cnt = 0;
		foreach (edge_vals[i]) begin
			foreach (edge_vals[j]) begin
				foreach (ops[k]) check_alu(ops[k], edge_vals[i], edge_vals[j]);
			end
		end
		repeat (6) begin
			foreach (ops[k]) check_alu(ops[k], rand_bits(DATA_W), rand_bits(DATA_W));
		end
		if (ov_cnt == 0) stop_run("no overflowing add or subtract was exercised");
	endtask

	task automatic test_multiply();
		foreach (edge_vals[i]) begin
			foreach (edge_vals[j]) begin
				check_mult(ex_pkg::EXE_MULT_OP, edge_vals[i], edge_vals[j]);
				check_mult(ex_pkg::EXE_MULTU_OP, edge_vals[i], edge_vals[j]);
			end
		end
	endtask

	task automatic test_hilo_moves();
		logic [DATA_W-1:0] v[6];
		logic [DATA_W-1:0] hi_cur;
		logic [DATA_W-1:0] lo_cur;
		logic [DATA_W-1:0] a;
		for (int src = 0; src < 4; src++) begin
			foreach (v[i]) v[i] = rand_bits(DATA_W);
			a      = rand_bits(DATA_W);
			hi_cur = src[1] ? v[2] : (src[0] ? v[4] : v[0]); // mem over wb over regs
			lo_cur = src[1] ? v[3] : (src[0] ? v[5] : v[1]);
			issue(ex_pkg::EXE_MFHI_OP, ex_pkg::EXE_RES_MOVE, a, '0, 1'b1);
			{hi, lo, mem_hi, mem_lo, wb_hi, wb_lo} <= {v[0], v[1], v[2], v[3], v[4], v[5]};
			mem_whilo <= src[1];
			wb_whilo  <= src[0];
			wait_result();
			expect_out(hi_cur, cur_wd, 1'b1, 1'b0, 1'b0, '0, '0, cur_exc);
			issue(ex_pkg::EXE_MFLO_OP, ex_pkg::EXE_RES_MOVE, a, '0, 1'b1);
			wait_result();
			expect_out(lo_cur, cur_wd, 1'b1, 1'b0, 1'b0, '0, '0, cur_exc);
			issue(ex_pkg::EXE_MTHI_OP, ex_pkg::EXE_RES_NOP, a, '0, 1'b0);
			wait_result();
			expect_out('0, cur_wd, 1'b0, 1'b0, 1'b1, a, lo_cur, cur_exc);
			issue(ex_pkg::EXE_MTLO_OP, ex_pkg::EXE_RES_NOP, a, '0, 1'b0);
			wait_result();
			expect_out('0, cur_wd, 1'b0, 1'b0, 1'b1, hi_cur, a, cur_exc);
		end
		wait_edges(1'b1, 1, "clearing the forwarding inputs");
		mem_whilo <= 1'b0;
		wb_whilo  <= 1'b0;
	endtask

	task automatic test_move_link();
		logic [DATA_W-1:0] a;
		a = rand_bits(DATA_W);
		issue(ex_pkg::EXE_MOVZ_OP, ex_pkg::EXE_RES_MOVE, a, '0, 1'b1);
		wait_result();
		expect_out(a, cur_wd, 1'b1, 1'b0, 1'b0, '0, '0, cur_exc);
		issue(ex_pkg::EXE_MOVN_OP, ex_pkg::EXE_RES_MOVE, a, rand_bits(DATA_W), 1'b1);
		wait_result();
		expect_out(a, cur_wd, 1'b1, 1'b0, 1'b0, '0, '0, cur_exc);
		issue(ex_pkg::EXE_NOP_OP, ex_pkg::EXE_RES_JUMP_BRANCH, a, rand_bits(DATA_W), 1'b1);
		wait_result();
		expect_out(cur_link, cur_wd, 1'b1, 1'b0, 1'b0, '0, '0, cur_exc);
	endtask

	// one new op every cycle with each result checked a cycle later
	task automatic test_back_to_back();
		ex_pkg::alu_op_e ops[6] = '{ex_pkg::EXE_ADDU_OP, ex_pkg::EXE_XOR_OP, ex_pkg::EXE_SRA_OP,
				ex_pkg::EXE_SLTU_OP, ex_pkg::EXE_NOR_OP, ex_pkg::EXE_SUB_OP};
		logic [DATA_W-1:0]             res[6];
		logic                          ov[6];
		logic [ex_pkg::REG_ADDR_W-1:0] wd_q[6];
		logic [ex_pkg::EXC_W-1:0]      exc_q[6];
		logic [DATA_W-1:0]             a;
		logic [DATA_W-1:0]             b;
		foreach (ops[i]) begin
			a      = rand_bits(DATA_W);
			b      = rand_bits(DATA_W);
			res[i] = alu_model(ops[i], a, b, ov[i]);
			issue(ops[i], sel_of(ops[i]), a, b, 1'b1);
			wd_q[i]  = cur_wd;
			exc_q[i] = cur_exc;
			if (i > 0) begin
				wait_edges(1'b0, 1, "sampling a back-to-back result");
				expect_out(res[i-1], wd_q[i-1], 1'b1, ov[i-1], 1'b0, '0, '0, exc_q[i-1]);
			end
		end
		wait_result();
		expect_out(res[5], wd_q[5], 1'b1, ov[5], 1'b0, '0, '0, exc_q[5]);
	endtask

	initial begin
		lfsr_state = LFSR_SEED;
		clk        = 1'b0;
		rst_n      = 1'b0;
		aluop      = ex_pkg::EXE_NOP_OP;
		alusel     = ex_pkg::EXE_RES_NOP;
		{reg1, reg2, link_addr, hi, lo} = '0;
		{mem_hi, mem_lo, wb_hi, wb_lo}  = '0;
		wd         = '0;
		wreg       = 1'b0;
		mem_whilo  = 1'b0;
		wb_whilo   = 1'b0;
		except_in  = '0;
		ov_cnt     = 0;
		test_reset();
		test_logic_shift();
		test_arith();
		test_multiply();
		test_hilo_moves();
		test_move_link();
		test_back_to_back();
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- ex_stage.f
source/ex_pkg.sv
source/hilo_if.sv
source/ex_alu.sv
source/ex_hilo.sv
source/ex_writeback.sv
source/ex_stage.sv
verification/ex_stage_tb.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
